//--- verilog.f
rtl/board_pkg.sv
rtl/serial_pkg.sv
rtl/uart_rx.sv
rtl/rom_loader.sv
rtl/sync_ram.sv
rtl/video_ram.sv
rtl/memory_map.sv
rtl/mini_computer_top.sv
bench/tb_mini_computer.sv

//--- Makefile
# Verilator build and run of the board memory testbench

VERILATOR ?= verilator
TOP       ?= tb_mini_computer
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_mini_computer.sv
module tb_mini_computer;

    timeunit 1ns;
    timeprecision 1ps;

    logic                             clk;
    logic                             reset;
    logic                             rx;
    logic [board_pkg::CPU_ADDR_W-1:0] cpu_addr;
    logic [board_pkg::DATA_W-1:0]     cpu_wdata;
    logic                             cpu_we;
    logic [board_pkg::VID_ADDR_W-1:0] vid_addr;
    logic                             cpu_step;
    logic [board_pkg::DATA_W-1:0]     cpu_rdata;
    logic [board_pkg::DATA_W-1:0]     vid_data;
    logic                             prg_active;

    logic [7:0]  ref_mem [0:65535];       // Image of the whole CPU space
    logic [15:0] addr_list [0:63];
    int          tag_q[$];                // Step whose cpu_rdata shows the read
    logic [15:0] addr_q[$];
    logic [7:0]  exp_q[$];
    int          step_count;              // Completed step cycles
    int          error_count;
    int          check_count;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    integer      seed;

    mini_computer_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_we     (cpu_we),
        .vid_addr   (vid_addr),
        .cpu_step   (cpu_step),
        .cpu_rdata  (cpu_rdata),
        .vid_data   (vid_data),
        .prg_active (prg_active)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;           // 10 MHz stand-in for the board clock
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // RAM 0000-3FFF, video B000-BFFF, BIOS E000-FFFF, rest reads 00
    function automatic logic [7:0] ref_read(input logic [15:0] addr);
        if (addr <= 16'h3FFF || (addr >= 16'hB000 && addr <= 16'hBFFF) || addr >= 16'hE000) begin
            return ref_mem[addr];
        end
        return 8'h00;
    endfunction

    // CPU writes land only in RAM and video RAM
    function automatic void ref_write(input logic [15:0] addr, input logic [7:0] data);
        if (addr <= 16'h3FFF || (addr >= 16'hB000 && addr <= 16'hBFFF)) begin
            ref_mem[addr] = data;
        end
    endfunction

    // Spread over 4000-AFFF and C000-DFFF
    function automatic logic [15:0] random_unmapped(input logic [31:0] r);
        logic [15:0] offset;
        offset = r[15:0] % 16'h9000;
        if (offset < 16'h7000) begin
            return 16'h4000 + offset;
        end
        return 16'hC000 + (offset - 16'h7000);
    endfunction

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("error %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout: %s did not happen in time", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // Step counter, stable at every falling edge
    always @(posedge clk) begin
        if (reset) begin
            step_count <= 0;
        end else if (cpu_step) begin
            step_count <= step_count + 1;
        end
    end

    // Read check, one step after the address went out
    initial begin
        forever begin
            @(negedge clk);
            if (cpu_step && tag_q.size() > 0 && tag_q[0] == step_count) begin
                check_value($sformatf("cpu_rdata at %h", addr_q[0]), cpu_rdata, exp_q[0]);
                void'(tag_q.pop_front());
                void'(addr_q.pop_front());
                void'(exp_q.pop_front());
            end
        end
    end

    // ----------------------------------------
    // Bus and serial drivers
    // ----------------------------------------
    task automatic bus_access(input logic [15:0] addr, input logic we, input logic [7:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!cpu_step) begin
            waited++;
            if (waited > 2 * board_pkg::STEP_DIV) begin
                timeout_fail("cpu_step");
            end
            @(negedge clk);
        end
        cpu_addr  = addr;                 // Held until the next step
        cpu_we    = we;
        cpu_wdata = data;
        if (we) begin
            ref_write(addr, data);
        end
        tag_q.push_back(step_count + 1);
        addr_q.push_back(addr);
        exp_q.push_back(ref_read(addr));
    endtask

    task automatic wait_checks_done();
        int waited;
        waited = 0;
        while (tag_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > 4 * board_pkg::STEP_DIV) begin
                timeout_fail("the last cpu_rdata check");
            end
        end
    endtask

    task automatic wait_prg(input logic level);
        int waited;
        waited = 0;
        while (prg_active !== level) begin
            @(negedge clk);
            waited++;
            if (waited > 12 * serial_pkg::BIT_CYCLES) begin
                timeout_fail(level ? "prg_active rise" : "prg_active fall");
            end
        end
    endtask

    task automatic hold_bit();
        repeat (serial_pkg::BIT_CYCLES) @(negedge clk);
    endtask

    // 8N1, LSB first, one idle bit after the stop bit
    task automatic send_byte(input logic [7:0] value);
        int b;
        rx = 1'b0;
        hold_bit();
        for (b = 0; b < 8; b++) begin
            rx = value[b];
            hold_bit();
        end
        rx = 1'b1;
        hold_bit();
        hold_bit();
    endtask

    task automatic start_test();
        test_errors = error_count;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = error_count - test_errors;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (errs == 0) ? "ok" : "failed", errs);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        int          i;
        logic [31:0] rnd;
        logic [15:0] ua;
        seed         = 32'he234;
        error_count  = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset        = 1'b1;
        rx           = 1'b1;              // Serial line idles high
        cpu_addr     = '0;
        cpu_wdata    = '0;
        cpu_we       = 1'b0;
        vid_addr     = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Strobe timing right after reset
        start_test();
        check_value("prg_active", {7'b0, prg_active}, 8'h00);
        check_value("cpu_step", {7'b0, cpu_step}, 8'h00);
        for (i = 1; i <= 3 * board_pkg::STEP_DIV; i++) begin
            @(negedge clk);
            check_value($sformatf("cpu_step after edge %0d", i), {7'b0, cpu_step},
                        (i % board_pkg::STEP_DIV == 0) ? 8'h01 : 8'h00);
        end
        end_test("reset and step strobe");

        start_test();
        for (i = 0; i < 64; i++) begin
            rnd          = $random(seed);
            addr_list[i] = {2'b00, rnd[13:0]};
            bus_access(addr_list[i], 1'b1, rnd[23:16]);
        end
        for (i = 0; i < 64; i++) begin
            bus_access(addr_list[i], 1'b0, 8'h00);
        end
        wait_checks_done();
        end_test("common RAM");

        start_test();
        for (i = 0; i < 32; i++) begin
            rnd          = $random(seed);
            addr_list[i] = {4'hB, rnd[11:0]};
            bus_access(addr_list[i], 1'b1, rnd[19:12]);
        end
        for (i = 0; i < 32; i++) begin
            bus_access(addr_list[i], 1'b0, 8'h00);
        end
        wait_checks_done();
        // Display port, data one cycle after the address
        for (i = 0; i < 32; i++) begin
            vid_addr = addr_list[i][11:0];
            @(negedge clk);
            check_value($sformatf("vid_data at %h", addr_list[i][11:0]), vid_data,
                        ref_read(addr_list[i]));
        end
        end_test("video RAM");

        start_test();
        for (i = 0; i < serial_pkg::ROM_BYTES; i++) begin
            rnd = $random(seed);
            ref_mem[16'hE000 + i[15:0]] = rnd[7:0];   // Image starts at the BIOS base
            send_byte(rnd[7:0]);
            if (i == 0) begin
                wait_prg(1'b1);
            end
            if (i == serial_pkg::ROM_BYTES - 2) begin
                check_value("prg_active before last byte", {7'b0, prg_active}, 8'h01);
            end
        end
        wait_prg(1'b0);
        for (i = 0; i < serial_pkg::ROM_BYTES; i++) begin
            bus_access(16'hE000 + i[15:0], 1'b0, 8'h00);
        end
        wait_checks_done();
        end_test("serial BIOS load");

        // BIOS and unmapped writes against aliased RAM and video cells
        start_test();
        for (i = 0; i < 16; i++) begin
            rnd = $random(seed);
            ua  = random_unmapped($random(seed));
            bus_access({2'b00, ua[13:0]}, 1'b1, rnd[7:0]);
            bus_access({4'hB, ua[11:0]}, 1'b1, rnd[15:8]);
            bus_access(ua, 1'b1, rnd[23:16]);
            bus_access({3'b111, ua[12:0]}, 1'b1, rnd[31:24]);
            bus_access({2'b00, ua[13:0]}, 1'b0, 8'h00);
            bus_access({4'hB, ua[11:0]}, 1'b0, 8'h00);
            bus_access(ua, 1'b0, 8'h00);
            bus_access({3'b111, ua[12:0]}, 1'b0, 8'h00);
        end
        wait_checks_done();
        end_test("protected and unmapped writes");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- rtl/mini_computer_top.sv
module mini_computer_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             rx,
    input  logic [board_pkg::CPU_ADDR_W-1:0] cpu_addr,
    input  logic [board_pkg::DATA_W-1:0]     cpu_wdata,
    input  logic                             cpu_we,
    input  logic [board_pkg::VID_ADDR_W-1:0] vid_addr,
    output logic                             cpu_step,
    output logic [board_pkg::DATA_W-1:0]     cpu_rdata,
    output logic [board_pkg::DATA_W-1:0]     vid_data,
    output logic                             prg_active
);

    logic [board_pkg::DATA_W-1:0]     rx_byte;
    logic                             rx_ready;
    logic [board_pkg::ROM_ADDR_W-1:0] rom_wr_addr;
    logic [board_pkg::DATA_W-1:0]     rom_wr_data;
    logic                             rom_wren;
    logic                             ram_wren;
    logic                             vid_wren;
    logic [board_pkg::DATA_W-1:0]     rom_q;
    logic [board_pkg::DATA_W-1:0]     ram_q;
    logic [board_pkg::DATA_W-1:0]     vid_cpu_q;

    // --------------------------------------
    // Serial loader into the BIOS ROM
    // --------------------------------------
    uart_rx u_uart_rx (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_ready (rx_ready)
    );

    rom_loader u_rom_loader (
        .clk         (clk),
        .reset       (reset),
        .rx_byte     (rx_byte),
        .rx_ready    (rx_ready),
        .rom_wr_addr (rom_wr_addr),
        .rom_wr_data (rom_wr_data),
        .rom_wren    (rom_wren),
        .prg_active  (prg_active)                    // Board LED
    );

    // --------------------------------------
    // CPU bus and memories
    // --------------------------------------
    memory_map u_memory_map (
        .clk       (clk),
        .reset     (reset),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_we    (cpu_we),
        .cpu_step  (cpu_step),
        .cpu_rdata (cpu_rdata),
        .ram_wren  (ram_wren),
        .vid_wren  (vid_wren),
        .rom_q     (rom_q),
        .ram_q     (ram_q),
        .vid_cpu_q (vid_cpu_q)
    );

    // E000-FFFF, written only by the loader
    sync_ram #(.ADDR_W(board_pkg::ROM_ADDR_W)) u_bios_rom (
        .clk     (clk),
        .wr_addr (rom_wr_addr),
        .wr_data (rom_wr_data),
        .wren    (rom_wren),
        .rd_addr (cpu_addr[board_pkg::ROM_ADDR_W-1:0]),
        .q       (rom_q)
    );

    // 0000-3FFF
    sync_ram #(.ADDR_W(board_pkg::RAM_ADDR_W)) u_common_ram (
        .clk     (clk),
        .wr_addr (cpu_addr[board_pkg::RAM_ADDR_W-1:0]),
        .wr_data (cpu_wdata),
        .wren    (ram_wren),
        .rd_addr (cpu_addr[board_pkg::RAM_ADDR_W-1:0]),
        .q       (ram_q)
    );

    // B000-BFFF, second port to the display
    video_ram u_video_ram (
        .clk       (clk),
        .cpu_addr  (cpu_addr[board_pkg::VID_ADDR_W-1:0]),
        .cpu_wdata (cpu_wdata),
        .cpu_wren  (vid_wren),
        .cpu_q     (vid_cpu_q),
        .disp_addr (vid_addr),
        .disp_q    (vid_data)
    );

endmodule

//--- rtl/memory_map.sv
module memory_map (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [board_pkg::CPU_ADDR_W-1:0] cpu_addr,
    input  logic [board_pkg::DATA_W-1:0]     cpu_wdata,
    input  logic                             cpu_we,
    output logic                             cpu_step,
    output logic [board_pkg::DATA_W-1:0]     cpu_rdata,
    output logic                             ram_wren,
    output logic                             vid_wren,
    input  logic [board_pkg::DATA_W-1:0]     rom_q,
    input  logic [board_pkg::DATA_W-1:0]     ram_q,
    input  logic [board_pkg::DATA_W-1:0]     vid_cpu_q
);

    logic [board_pkg::STEP_CNT_W-1:0] step_cnt;
    logic                             step_d;     // Cycle after a CPU step
    board_pkg::region_t               region;
    board_pkg::region_t               rd_region;  // Region of the sampled address

    // Compare the bits above each region's size with its base
    function automatic board_pkg::region_t decode(
        input logic [board_pkg::CPU_ADDR_W-1:0] addr
    );
        if ((addr >> board_pkg::ROM_ADDR_W) == (board_pkg::ROM_BASE >> board_pkg::ROM_ADDR_W))
            return board_pkg::REG_ROM;
        if ((addr >> board_pkg::RAM_ADDR_W) == (board_pkg::RAM_BASE >> board_pkg::RAM_ADDR_W))
            return board_pkg::REG_RAM;
        if ((addr >> board_pkg::VID_ADDR_W) == (board_pkg::VID_BASE >> board_pkg::VID_ADDR_W))
            return board_pkg::REG_VID;
        return board_pkg::REG_NONE;
    endfunction

    // --------------------------------------
    // CPU step strobe
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            step_cnt <= '0;
            cpu_step <= 1'b0;
            step_d   <= 1'b0;
        end else begin
            step_cnt <= (step_cnt == board_pkg::STEP_LAST) ? '0 : step_cnt + 1'b1;
            cpu_step <= (step_cnt == board_pkg::STEP_LAST);  // First on the 4th edge
            step_d   <= cpu_step;
        end
    end

    // Delayed write once the bus has settled after the step
    assign region   = decode(cpu_addr);
    assign ram_wren = step_d && cpu_we && (region == board_pkg::REG_RAM);
    assign vid_wren = step_d && cpu_we && (region == board_pkg::REG_VID);  // ROM never written

    // --------------------------------------
    // Read data select
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_region <= board_pkg::REG_NONE;
        end else begin
            rd_region <= region;                     // Same edge as the memory reads
        end
    end

    always_ff @(posedge clk) begin
        case (rd_region)
            board_pkg::REG_ROM: cpu_rdata <= rom_q;
            board_pkg::REG_RAM: cpu_rdata <= ram_q;
            board_pkg::REG_VID: cpu_rdata <= vid_cpu_q;
            default:            cpu_rdata <= '0;     // Unmapped
        endcase
    end

    // At most one memory takes a CPU write
    assert property (@(posedge clk) disable iff (reset) !(ram_wren && vid_wren));

endmodule

//--- rtl/video_ram.sv
module video_ram (
    input  logic                             clk,
    // CPU side
    input  logic [board_pkg::VID_ADDR_W-1:0] cpu_addr,
    input  logic [board_pkg::DATA_W-1:0]     cpu_wdata,
    input  logic                             cpu_wren,
    output logic [board_pkg::DATA_W-1:0]     cpu_q,
    // Display side, read only
    input  logic [board_pkg::VID_ADDR_W-1:0] disp_addr,
    output logic [board_pkg::DATA_W-1:0]     disp_q
);

    // --------------------------------------
    // Text memory, char and attribute bytes
    // --------------------------------------
    logic [board_pkg::DATA_W-1:0] mem [0:(1 << board_pkg::VID_ADDR_W)-1];

    // CPU port, write plus readback
    always_ff @(posedge clk) begin
        if (cpu_wren) begin
            mem[cpu_addr] <= cpu_wdata;
        end
        cpu_q <= mem[cpu_addr];
    end

    // Display scan port
    always_ff @(posedge clk) begin
        disp_q <= mem[disp_addr];                    // One cycle behind disp_addr
    end

endmodule

//--- rtl/sync_ram.sv
module sync_ram #(
    parameter int ADDR_W = 13
) (
    input  logic                         clk,
    input  logic [ADDR_W-1:0]            wr_addr,
    input  logic [board_pkg::DATA_W-1:0] wr_data,
    input  logic                         wren,
    input  logic [ADDR_W-1:0]            rd_addr,
    output logic [board_pkg::DATA_W-1:0] q
);

    // --------------------------------------
    // Block RAM, one write and one read port
    // --------------------------------------
    logic [board_pkg::DATA_W-1:0] mem [0:(1 << ADDR_W)-1];

    // Write port
    always_ff @(posedge clk) begin
        if (wren) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        q <= mem[rd_addr];
    end

endmodule

//--- rtl/rom_loader.sv
module rom_loader (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [board_pkg::DATA_W-1:0]  rx_byte,
    input  logic                          rx_ready,
    output logic [board_pkg::ROM_ADDR_W-1:0] rom_wr_addr,
    output logic [board_pkg::DATA_W-1:0]  rom_wr_data,
    output logic                          rom_wren,
    output logic                          prg_active
);

    logic last_wr;

    // Write to the top of the image closes the load
    assign last_wr = rom_wren && (int'(rom_wr_addr) == serial_pkg::ROM_BYTES - 1);

    // --------------------------------------
    // Load address and loading flag
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rom_wr_addr <= '0;
            rom_wren    <= 1'b0;
            prg_active  <= 1'b0;
        end else begin
            rom_wren <= rx_ready;                    // One cycle behind the byte
            if (rx_ready) begin
                if (!prg_active) begin
                    prg_active  <= 1'b1;             // First byte, LED on
                    rom_wr_addr <= '0;
                end else begin
                    rom_wr_addr <= rom_wr_addr + 1'b1;
                end
            end else if (last_wr) begin
                prg_active <= 1'b0;                  // Image complete
            end
        end
    end

    // Byte latch
    always_ff @(posedge clk) begin
        if (rx_ready) begin
            rom_wr_data <= rx_byte;
        end
    end

    // ROM writes come only from a received byte
    assert property (@(posedge clk) disable iff (reset) rom_wren |-> $past(rx_ready));

endmodule

//--- rtl/uart_rx.sv
module uart_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_ready
);

    logic                             rx_meta;
    logic                             rx_sync;
    serial_pkg::rx_state_t            state;
    logic [serial_pkg::BIT_TMR_W-1:0] bit_tmr;
    logic [2:0]                       bit_cnt;  // Data bit index
    logic [7:0]                       shift;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // --------------------------------------
    // Receiver FSM
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= serial_pkg::RX_IDLE;
            bit_tmr  <= '0;
            bit_cnt  <= '0;
            rx_ready <= 1'b0;
        end else begin
            rx_ready <= 1'b0;                        // Single-cycle strobe
            case (state)
                serial_pkg::RX_IDLE: begin
                    bit_tmr <= '0;
                    if (!rx_sync) begin
                        state <= serial_pkg::RX_START;
                    end
                end
                serial_pkg::RX_START: begin
                    if (bit_tmr == serial_pkg::HALF_LAST) begin
                        bit_tmr <= '0;
                        bit_cnt <= '0;
                        // Still low in mid-bit, otherwise a glitch
                        state   <= rx_sync ? serial_pkg::RX_IDLE : serial_pkg::RX_DATA;
                    end else begin
                        bit_tmr <= bit_tmr + 1'b1;
                    end
                end
                serial_pkg::RX_DATA: begin
                    if (bit_tmr == serial_pkg::BIT_LAST) begin
                        bit_tmr <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= serial_pkg::RX_STOP;
                        end
                    end else begin
                        bit_tmr <= bit_tmr + 1'b1;
                    end
                end
                serial_pkg::RX_STOP: begin
                    if (bit_tmr == serial_pkg::BIT_LAST) begin
                        state    <= serial_pkg::RX_IDLE;
                        rx_ready <= rx_sync;                 // Framing error drops the byte
                    end else begin
                        bit_tmr <= bit_tmr + 1'b1;
                    end
                end
                default: state <= serial_pkg::RX_IDLE;
            endcase
        end
    end

    // Data path, sampled in mid-bit
    always_ff @(posedge clk) begin
        if (state == serial_pkg::RX_DATA && bit_tmr == serial_pkg::BIT_LAST) begin
            shift <= {rx_sync, shift[7:1]};              // LSB arrives first
        end
        if (state == serial_pkg::RX_STOP && bit_tmr == serial_pkg::BIT_LAST) begin
            rx_byte <= shift;
        end
    end

    // Byte strobe never stretches, the loader counts one byte per pulse
    assert property (@(posedge clk) disable iff (reset) rx_ready |=> !rx_ready);

endmodule

//--- rtl/serial_pkg.sv
package serial_pkg;

    // --------------------------------------
    // Bit timing
    // --------------------------------------
    localparam int BIT_CYCLES = 4;                    // Clocks per serial bit
    localparam int BIT_TMR_W  = $clog2(BIT_CYCLES);

    // Timer end values, full bit and half bit
    localparam logic [BIT_TMR_W-1:0] BIT_LAST  = BIT_TMR_W'(BIT_CYCLES - 1);
    localparam logic [BIT_TMR_W-1:0] HALF_LAST = BIT_TMR_W'(BIT_CYCLES / 2 - 1);

    // One full BIOS image
    localparam int ROM_BYTES = 8192;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,     // Line high, waiting for a falling edge
        RX_START,    // Half a bit into the start bit
        RX_DATA,     // Eight data bits, LSB first
        RX_STOP      // Stop bit check
    } rx_state_t;

endpackage

//--- rtl/board_pkg.sv
package board_pkg;

    // --------------------------------------
    // Bus widths
    // --------------------------------------
    localparam int CPU_ADDR_W = 16;   // 64 KB CPU space
    localparam int DATA_W     = 8;
    localparam int ROM_ADDR_W = 13;   // 8 KB BIOS
    localparam int RAM_ADDR_W = 14;   // 16 KB common RAM
    localparam int VID_ADDR_W = 12;   // 4 KB text memory

    // CPU step strobe, 100 MHz board clock down to 25 MHz
    localparam int STEP_DIV   = 4;
    localparam int STEP_CNT_W = $clog2(STEP_DIV);
    localparam logic [STEP_CNT_W-1:0] STEP_LAST = STEP_CNT_W'(STEP_DIV - 1);

    // --------------------------------------
    // Region bases in the CPU space
    // --------------------------------------
    localparam logic [CPU_ADDR_W-1:0] ROM_BASE = 16'hE000;  // E000-FFFF
    localparam logic [CPU_ADDR_W-1:0] RAM_BASE = 16'h0000;  // 0000-3FFF
    localparam logic [CPU_ADDR_W-1:0] VID_BASE = 16'hB000;  // B000-BFFF

    // Which memory answers an address
    typedef enum logic [1:0] {
        REG_ROM,
        REG_RAM,
        REG_VID,
        REG_NONE     // Reads 00, writes dropped
    } region_t;

endpackage
